//--- Makefile
# Verilator build and run for the EX/MEM/WB slice

VERILATOR ?= verilator
TOP       ?= tb_ex_mem_wb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails on a nonzero exit or when the log holds the fail message
run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+src
src/rv32_ctrl_pkg.sv
src/rv32_data_pkg.sv
src/mem_access_if.sv
src/alu.sv
src/stage_register.sv
src/data_memory.sv
src/writeback_select.sv
src/ex_mem_wb_top.sv
verification/tb_ex_mem_wb.sv

//--- src/alu.sv
`default_nettype none
`include "rv32_config.svh"

module alu (
    input  rv32_ctrl_pkg::alu_op_t op,
    input  rv32_data_pkg::word_t   a,
    input  rv32_data_pkg::word_t   b,
    output rv32_data_pkg::word_t   y
);
    import rv32_ctrl_pkg::*;

    localparam int SHAMT_W = $clog2(`RV32_XLEN);

    // Shift amount, upper bits of b ignored
    logic [SHAMT_W-1:0] shamt;
    // Compare results for SLT and SLTU
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = b[SHAMT_W-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            // Compares give 0 or 1
            ALU_SLT:  y = {{(`RV32_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: y = {{(`RV32_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  y = $signed(a) >>> shamt;
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            // Unused encodings
            default:  y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/data_memory.sv
`default_nettype none
`include "rv32_config.svh"

module data_memory (
    input logic          CLK,
    mem_access_if.memory bus
);
    import rv32_ctrl_pkg::*;
    import rv32_data_pkg::*;

    localparam int DEPTH = `RV32_DMEM_WORDS;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int LANES = `RV32_XLEN / 8;

    word_t              mem [DEPTH];
    logic [IDX_W-1:0]   idx;
    logic [1:0]         byte_off;
    logic [LANES-1:0]   be;
    word_t              wr_lanes;
    word_t              rd_word;
    logic [7:0]         rd_byte;
    logic [15:0]        rd_half;

    // Word index and lane offset
    assign idx      = bus.addr[IDX_W+1:2];
    assign byte_off = bus.addr[1:0];

    ////////////////////////////////////////
    // Store path
    ////////////////////////////////////////

    // Replicate data across lanes, strobe picks the live one
    always_comb begin
        be       = '0;
        wr_lanes = bus.wdata;
        case (bus.width)
            MEM_B: begin
                be       = LANES'(1) << byte_off;
                wr_lanes = {LANES{bus.wdata[7:0]}};
            end
            MEM_H: begin
                be       = LANES'(3) << {byte_off[1], 1'b0};
                wr_lanes = {(LANES/2){bus.wdata[15:0]}};
            end
            MEM_W:   be = '1;
            // No unsigned stores in RV32I
            default: be = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            if (bus.we && be[i]) begin
                mem[idx][8*i +: 8] <= wr_lanes[8*i +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Load path
    ////////////////////////////////////////

    // Asynchronous read, same cycle as the address
    assign rd_word = mem[idx];
    assign rd_byte = rd_word[8*byte_off +: 8];
    assign rd_half = rd_word[16*byte_off[1] +: 16];

    always_comb begin
        case (bus.width)
            MEM_B:   bus.rdata = {{(`RV32_XLEN-8){rd_byte[7]}}, rd_byte};
            MEM_H:   bus.rdata = {{(`RV32_XLEN-16){rd_half[15]}}, rd_half};
            MEM_BU:  bus.rdata = {{(`RV32_XLEN-8){1'b0}}, rd_byte};
            MEM_HU:  bus.rdata = {{(`RV32_XLEN-16){1'b0}}, rd_half};
            default: bus.rdata = rd_word;
        endcase
    end

    // Misaligned stores are not trapped, catch them here
    a_half_aligned: assert property (
        @(posedge CLK) (bus.we && bus.width == MEM_H) |-> !bus.addr[0]
    );
    a_word_aligned: assert property (
        @(posedge CLK) (bus.we && bus.width == MEM_W) |-> (bus.addr[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

//--- src/ex_mem_wb_top.sv
`default_nettype none

module ex_mem_wb_top (
    input  logic                       CLK,
    input  logic                       RST,
    input  logic                       FLUSH,
    input  logic                       VALID_E,
    input  rv32_ctrl_pkg::alu_op_t     ALU_OP_E,
    input  rv32_data_pkg::word_t       SRC_A_E,
    input  rv32_data_pkg::word_t       SRC_B_E,
    input  logic                       REG_W_EN_E,
    input  logic                       MEM_W_EN_E,
    input  rv32_ctrl_pkg::mem_ctrl_t   MEM_CONTROL_E,
    input  rv32_ctrl_pkg::result_src_t RESULT_SRC_E,
    input  rv32_data_pkg::reg_addr_t   RD_E,
    input  rv32_data_pkg::word_t       STORE_DATA_E,
    input  rv32_data_pkg::word_t       PC_PLUS_4_E,
    output logic                       WB_VALID,
    output logic                       REG_W_EN_W,
    output rv32_data_pkg::reg_addr_t   RD_W,
    output rv32_data_pkg::word_t       RESULT_W
);
    import rv32_data_pkg::*;

    word_t          alu_out_e;
    exmem_payload_t exmem_d;
    exmem_payload_t exmem_q;
    logic           exmem_valid;
    memwb_payload_t memwb_d;
    memwb_payload_t memwb_q;
    logic           memwb_valid;

    mem_access_if dmem_bus ();

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    alu i_alu (
        .op (ALU_OP_E),
        .a  (SRC_A_E),
        .b  (SRC_B_E),
        .y  (alu_out_e)
    );

    assign exmem_d = '{
        reg_w_en:    REG_W_EN_E,
        mem_w_en:    MEM_W_EN_E,
        mem_control: MEM_CONTROL_E,
        result_src:  RESULT_SRC_E,
        rd:          RD_E,
        store_data:  STORE_DATA_E,
        alu_out:     alu_out_e,
        pc_plus_4:   PC_PLUS_4_E
    };

    // Flush squashes the entry at capture
    stage_register #(.PAYLOAD_T(exmem_payload_t)) i_exmem_reg (
        .CLK       (CLK),
        .RST       (RST),
        .flush     (FLUSH),
        .valid_in  (VALID_E),
        .d         (exmem_d),
        .valid_out (exmem_valid),
        .q         (exmem_q)
    );

    ////////////////////////////////////////
    // Memory
    ////////////////////////////////////////

    assign dmem_bus.addr  = exmem_q.alu_out;
    assign dmem_bus.wdata = exmem_q.store_data;
    assign dmem_bus.width = exmem_q.mem_control;
    // Invalid entries never store
    assign dmem_bus.we    = exmem_q.mem_w_en & exmem_valid;

    data_memory i_data_memory (
        .CLK (CLK),
        .bus (dmem_bus.memory)
    );

    assign memwb_d = '{
        reg_w_en:   exmem_q.reg_w_en,
        result_src: exmem_q.result_src,
        rd:         exmem_q.rd,
        alu_out:    exmem_q.alu_out,
        load_data:  dmem_bus.rdata,
        pc_plus_4:  exmem_q.pc_plus_4
    };

    // No squash past the memory stage
    stage_register #(.PAYLOAD_T(memwb_payload_t)) i_memwb_reg (
        .CLK       (CLK),
        .RST       (RST),
        .flush     (1'b0),
        .valid_in  (exmem_valid),
        .d         (memwb_d),
        .valid_out (memwb_valid),
        .q         (memwb_q)
    );

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    writeback_select i_wb_select (
        .valid    (memwb_valid),
        .p        (memwb_q),
        .wb_valid (WB_VALID),
        .reg_w_en (REG_W_EN_W),
        .rd       (RD_W),
        .result   (RESULT_W)
    );

endmodule

`default_nettype wire

//--- src/mem_access_if.sv
`default_nettype none

interface mem_access_if;
    import rv32_ctrl_pkg::*;
    import rv32_data_pkg::*;

    // Byte address, from the ALU result
    word_t     addr;
    // Store data, unshifted
    word_t     wdata;
    // Store strobe, already qualified by stage valid
    logic      we;
    // Access size and load extension
    mem_ctrl_t width;
    // Load data, already extended
    word_t     rdata;

    // Pipeline side
    modport requester (output addr, wdata, we, width, input rdata);

    // Memory side
    modport memory (input addr, wdata, we, width, output rdata);

endinterface

`default_nettype wire

//--- src/rv32_config.svh
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Integer register and data word width
`define RV32_XLEN 32

// Register index width, x0 to x31
`define RV32_REG_ADDR_W 5

// Data memory depth in 32-bit words
// Power of two, so the word index is a plain bit slice of the address
`define RV32_DMEM_WORDS 256

`endif

//--- src/rv32_ctrl_pkg.sv
`default_nettype none

package rv32_ctrl_pkg;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////

    // Low 3 bits follow funct3, bit 3 is instr[30]
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_t;

    // Load/store width, same as RV32I funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_ctrl_t;

    // Writeback value source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_t;

endpackage

`default_nettype wire

//--- src/rv32_data_pkg.sv
`default_nettype none
`include "rv32_config.svh"

package rv32_data_pkg;
    import rv32_ctrl_pkg::*;

    typedef logic [`RV32_XLEN-1:0]       word_t;
    typedef logic [`RV32_REG_ADDR_W-1:0] reg_addr_t;

    // Execute to memory stage contents
    typedef struct packed {
        logic        reg_w_en;
        logic        mem_w_en;
        mem_ctrl_t   mem_control;
        result_src_t result_src;
        reg_addr_t   rd;
        word_t       store_data;
        word_t       alu_out;
        word_t       pc_plus_4;
    } exmem_payload_t;

    // Memory to writeback stage contents
    // Store side controls are dropped here
    typedef struct packed {
        logic        reg_w_en;
        result_src_t result_src;
        reg_addr_t   rd;
        word_t       alu_out;
        word_t       load_data;
        word_t       pc_plus_4;
    } memwb_payload_t;

endpackage

`default_nettype wire

//--- src/stage_register.sv
`default_nettype none

module stage_register #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     CLK,
    input  logic     RST,
    input  logic     flush,
    input  logic     valid_in,
    input  PAYLOAD_T d,
    output logic     valid_out,
    output PAYLOAD_T q
);

    // Valid bit, squashed by reset or flush
    always_ff @(posedge CLK) begin
        if (RST || flush) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // Payload loads every cycle, qualified downstream by valid
    always_ff @(posedge CLK) begin
        q <= d;
    end

    // Stage must come out of reset empty
    a_empty_after_reset: assert property (
        @(posedge CLK) RST |=> !valid_out
    );

endmodule

`default_nettype wire

//--- src/writeback_select.sv
`default_nettype none

module writeback_select (
    input  logic                         valid,
    input  rv32_data_pkg::memwb_payload_t p,
    output logic                         wb_valid,
    output logic                         reg_w_en,
    output rv32_data_pkg::reg_addr_t     rd,
    output rv32_data_pkg::word_t         result
);
    import rv32_ctrl_pkg::*;

    // Result mux
    always_comb begin
        case (p.result_src)
            RES_ALU: result = p.alu_out;
            RES_MEM: result = p.load_data;
            RES_PC4: result = p.pc_plus_4;
            // Reserved encoding, fall back to ALU
            default: result = p.alu_out;
        endcase
    end

    // Bubble or flushed entry never writes
    assign reg_w_en = valid & p.reg_w_en;
    assign wb_valid = valid;
    assign rd       = p.rd;

endmodule

`default_nettype wire

//--- verification/tb_ex_mem_wb.sv
`default_nettype none
`include "rv32_config.svh"

module tb_ex_mem_wb;
    import rv32_ctrl_pkg::*;
    import rv32_data_pkg::*;

    localparam int MEM_BYTES   = 4 * `RV32_DMEM_WORDS;
    localparam int BYTE_AW     = $clog2(MEM_BYTES);
    localparam int DRAIN_LIMIT = 64;

    // One expected writeback
    typedef struct {
        word_t     result;
        reg_addr_t rd;
        logic      reg_w_en;
        int        due;
    } exp_t;

    logic        CLK;
    logic        RST;
    logic        FLUSH;
    logic        VALID_E;
    alu_op_t     ALU_OP_E;
    word_t       SRC_A_E;
    word_t       SRC_B_E;
    logic        REG_W_EN_E;
    logic        MEM_W_EN_E;
    mem_ctrl_t   MEM_CONTROL_E;
    result_src_t RESULT_SRC_E;
    reg_addr_t   RD_E;
    word_t       STORE_DATA_E;
    word_t       PC_PLUS_4_E;
    logic        WB_VALID;
    logic        REG_W_EN_W;
    reg_addr_t   RD_W;
    word_t       RESULT_W;

    // Writebacks in flight in issue order
    exp_t        expected[$];
    // Byte image of the data memory
    logic [7:0]  shadow [MEM_BYTES];
    logic [31:0] lfsr_state;
    int          neg_count;
    int          errors;
    int          checks;

    ex_mem_wb_top i_ex_mem_wb_top (
        .CLK           (CLK),
        .RST           (RST),
        .FLUSH         (FLUSH),
        .VALID_E       (VALID_E),
        .ALU_OP_E      (ALU_OP_E),
        .SRC_A_E       (SRC_A_E),
        .SRC_B_E       (SRC_B_E),
        .REG_W_EN_E    (REG_W_EN_E),
        .MEM_W_EN_E    (MEM_W_EN_E),
        .MEM_CONTROL_E (MEM_CONTROL_E),
        .RESULT_SRC_E  (RESULT_SRC_E),
        .RD_E          (RD_E),
        .STORE_DATA_E  (STORE_DATA_E),
        .PC_PLUS_4_E   (PC_PLUS_4_E),
        .WB_VALID      (WB_VALID),
        .REG_W_EN_W    (REG_W_EN_W),
        .RD_W          (RD_W),
        .RESULT_W      (RESULT_W)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    ////////////////////////////////////////
    // Random source and reference models
    ////////////////////////////////////////

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'h80200003;
        return out;
    endfunction

    // n random bits from the LSB up
    function automatic word_t lfsr_word(int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) w[i] = next_bit();
        return w;
    endfunction

    function automatic word_t alu_expect(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    // Little-endian byte lanes sized by funct3
    task automatic record_store(mem_ctrl_t w, word_t addr, word_t data);
        logic [BYTE_AW-1:0] base;
        int                 n;
        base = addr[BYTE_AW-1:0];
        n = 1;
        if (w == MEM_H) begin
            n = 2;
            base[0] = 1'b0;
        end else if (w == MEM_W) begin
            n = 4;
            base[1:0] = 2'b00;
        end
        for (int i = 0; i < n; i++) shadow[base | BYTE_AW'(i)] = data[8*i +: 8];
    endtask

    function automatic word_t shadow_load(mem_ctrl_t w, word_t addr);
        logic [BYTE_AW-1:0] base;
        word_t              v;
        int                 n;
        base = addr[BYTE_AW-1:0];
        n = 4;
        if (w == MEM_B || w == MEM_BU) begin
            n = 1;
        end else if (w == MEM_H || w == MEM_HU) begin
            n = 2;
            base[0] = 1'b0;
        end else begin
            base[1:0] = 2'b00;
        end
        v = '0;
        for (int i = 0; i < n; i++) v[8*i +: 8] = shadow[base | BYTE_AW'(i)];
        // Signed loads replicate the top bit
        if (w == MEM_B) v = {{24{v[7]}}, v[7:0]};
        if (w == MEM_H) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic word_match(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reg_match(string name, reg_addr_t got, reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic bit_match(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Drivers and monitor
    ////////////////////////////////////////

    // Drive one operation and queue its writeback unless flushed
    task automatic issue(alu_op_t op, word_t a, word_t b, logic reg_w, logic mem_w,
                         mem_ctrl_t mc, result_src_t rs, reg_addr_t rd, word_t sd,
                         word_t pc4, logic flush, word_t exp_result);
        exp_t e;
        @(posedge CLK);
        VALID_E       <= 1'b1;
        ALU_OP_E      <= op;
        SRC_A_E       <= a;
        SRC_B_E       <= b;
        REG_W_EN_E    <= reg_w;
        MEM_W_EN_E    <= mem_w;
        MEM_CONTROL_E <= mc;
        RESULT_SRC_E  <= rs;
        RD_E          <= rd;
        STORE_DATA_E  <= sd;
        PC_PLUS_4_E   <= pc4;
        FLUSH         <= flush;
        if (!flush) begin
            e.result   = exp_result;
            e.rd       = rd;
            e.reg_w_en = reg_w;
            // Captured at the next edge and two register stages to writeback
            e.due      = neg_count + 3;
            expected.push_back(e);
        end
    endtask

    // Address comes from the ALU as addr + 0
    task automatic mem_op(logic store, mem_ctrl_t w, word_t addr, word_t data, logic flush);
        word_t       exp;
        result_src_t rs;
        if (store) begin
            exp = addr;
            rs  = RES_ALU;
            if (!flush) record_store(w, addr, data);
        end else begin
            exp = shadow_load(w, addr);
            rs  = RES_MEM;
        end
        issue(ALU_ADD, addr, '0, !store, store, w, rs, reg_addr_t'(lfsr_word(5)), data,
              '0, flush, exp);
    endtask

    task automatic idle_inputs();
        @(posedge CLK);
        VALID_E    <= 1'b0;
        FLUSH      <= 1'b0;
        REG_W_EN_E <= 1'b0;
        MEM_W_EN_E <= 1'b0;
    endtask

    // Stop issuing then wait for every queued writeback
    task automatic wait_drained();
        int waited;
        idle_inputs();
        waited = 0;
        while (expected.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        if (expected.size() != 0) begin
            errors++;
            $display("Timeout at %0t: %0d writebacks never arrived", $time, expected.size());
            expected.delete();
        end
    endtask

    // Outputs settle on the rising edge and are checked on the falling one
    task automatic monitor_writeback();
        exp_t e;
        forever begin
            @(negedge CLK);
            neg_count++;
            if (WB_VALID === 1'b1) begin
                if (expected.size() == 0) begin
                    errors++;
                    $display("Unexpected writeback at %0t with nothing in flight", $time);
                end else begin
                    e = expected.pop_front();
                    word_match("RESULT_W", RESULT_W, e.result);
                    reg_match("RD_W", RD_W, e.rd);
                    bit_match("REG_W_EN_W", REG_W_EN_W, e.reg_w_en);
                    if (neg_count != e.due) begin
                        errors++;
                        $display("Writeback at cycle %0d was due at cycle %0d", neg_count, e.due);
                    end
                end
            end
        end
    endtask

    task automatic print_test_result(string name, int start_errors);
        $display("Test %s finished with %0d errors", name, errors - start_errors);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Payload still holds a register write that only valid can gate
    task automatic idle_after_reset();
        int start;
        start = errors;
        repeat (4) begin
            @(negedge CLK);
            bit_match("WB_VALID", WB_VALID, 1'b0);
            bit_match("REG_W_EN_W", REG_W_EN_W, 1'b0);
        end
        print_test_result("idle_after_reset", start);
    endtask

    // Every ALU op twice back to back
    task automatic alu_sweep();
        alu_op_t ops[10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                             ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
        word_t   a;
        word_t   b;
        int      start;
        start = errors;
        repeat (2) begin
            foreach (ops[i]) begin
                a = lfsr_word(32);
                b = lfsr_word(32);
                issue(ops[i], a, b, 1'b1, 1'b0, MEM_W, RES_ALU, reg_addr_t'(lfsr_word(5)),
                      '0, '0, 1'b0, alu_expect(ops[i], a, b));
            end
        end
        wait_drained();
        print_test_result("alu_sweep", start);
    endtask

    task automatic load_store_widths();
        word_t addr;
        word_t ba;
        word_t ha;
        int    start;
        start = errors;
        repeat (3) begin
            addr = lfsr_word(8) << 2;
            mem_op(1'b1, MEM_W, addr, lfsr_word(32), 1'b0);
            // Load on the very next cycle
            mem_op(1'b0, MEM_W, addr, '0, 1'b0);
            ba = addr | lfsr_word(2);
            mem_op(1'b1, MEM_B, ba, lfsr_word(32), 1'b0);
            mem_op(1'b0, MEM_B, ba, '0, 1'b0);
            mem_op(1'b0, MEM_BU, ba, '0, 1'b0);
            ha = addr | (lfsr_word(1) << 1);
            mem_op(1'b1, MEM_H, ha, lfsr_word(32), 1'b0);
            mem_op(1'b0, MEM_H, ha, '0, 1'b0);
            mem_op(1'b0, MEM_HU, ha, '0, 1'b0);
            mem_op(1'b0, MEM_W, addr, '0, 1'b0);
        end
        wait_drained();
        print_test_result("load_store_widths", start);
    endtask

    task automatic pc_plus_4_select();
        word_t pc4;
        int    start;
        start = errors;
        repeat (4) begin
            pc4 = lfsr_word(30) << 2;
            issue(ALU_XOR, lfsr_word(32), lfsr_word(32), 1'b1, 1'b0, MEM_W, RES_PC4,
                  reg_addr_t'(lfsr_word(5)), '0, pc4, 1'b0, pc4);
        end
        wait_drained();
        print_test_result("pc_plus_4_select", start);
    endtask

    task automatic flush_squash();
        word_t addr;
        int    start;
        start = errors;
        addr = lfsr_word(8) << 2;
        mem_op(1'b1, MEM_W, addr, lfsr_word(32), 1'b0);
        // Squashed store leaves the old word for the load
        mem_op(1'b1, MEM_W, addr, lfsr_word(32), 1'b1);
        mem_op(1'b0, MEM_W, addr, '0, 1'b0);
        wait_drained();
        issue(ALU_ADD, lfsr_word(32), lfsr_word(32), 1'b1, 1'b0, MEM_W, RES_ALU,
              reg_addr_t'(lfsr_word(5)), '0, '0, 1'b1, '0);
        idle_inputs();
        repeat (3) begin
            @(negedge CLK);
            bit_match("WB_VALID", WB_VALID, 1'b0);
            bit_match("REG_W_EN_W", REG_W_EN_W, 1'b0);
        end
        print_test_result("flush_squash", start);
    endtask

    initial begin
        lfsr_state    = 32'd10;
        neg_count     = 0;
        errors        = 0;
        checks        = 0;
        RST           = 1'b1;
        FLUSH         = 1'b0;
        // Live valid and register write that reset must squash
        VALID_E       = 1'b1;
        ALU_OP_E      = ALU_ADD;
        SRC_A_E       = '0;
        SRC_B_E       = '0;
        REG_W_EN_E    = 1'b1;
        MEM_W_EN_E    = 1'b0;
        MEM_CONTROL_E = MEM_W;
        RESULT_SRC_E  = RES_ALU;
        RD_E          = '0;
        STORE_DATA_E  = '0;
        PC_PLUS_4_E   = '0;
        fork
            monitor_writeback();
        join_none
        repeat (16) @(posedge CLK);
        RST     <= 1'b0;
        VALID_E <= 1'b0;
        idle_after_reset();
        alu_sweep();
        load_store_widths();
        pc_plus_4_select();
        flush_squash();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
